/* common/fec_defines.svh */
`ifndef FEC_DEFINES_SVH
`define FEC_DEFINES_SVH

// --------------------
// buffer geometry
// --------------------

// ping-pong buffers and the width of a buffer index.
`define FEC_NUM_BUFS 2
`define FEC_BUF_IDX_WID 1

// ram organisation inside one buffer.
`define FEC_NUM_BANKS 4
`define FEC_RAMS_PER_BANK 2

// rows per block and ram address width.
`define FEC_DEPTH 512
`define FEC_ADDR_WID 9

// one ram slice and one full row.
`define FEC_RAM_WID 64
`define FEC_WORD_WID 512

// --------------------
// interleave
// --------------------

// columns per block, must divide FEC_DEPTH.
`define FEC_STRIDE 8

`endif

/* common/fec_pkg.sv */
`include "fec_defines.svh"

package fec_pkg;

    // --------------------
    // datapath types
    // --------------------

    // one row of column data.
    typedef logic [`FEC_WORD_WID-1:0] col_word_t;

    // write request into a buffer.
    typedef struct packed {
        logic                     en;
        logic [`FEC_ADDR_WID-1:0] addr;
        col_word_t                data;
    } buf_wr_t;

    // read request into a buffer.
    typedef struct packed {
        logic                     en;
        logic [`FEC_ADDR_WID-1:0] addr;
    } buf_rd_t;

    // --------------------
    // control types
    // --------------------

    // life cycle of one ping-pong buffer.
    typedef enum logic [1:0] {
        BUF_EMPTY    = 2'd0,
        BUF_FILLING  = 2'd1,
        BUF_FULL     = 2'd2,
        BUF_DRAINING = 2'd3
    } buf_state_e;

endpackage

/* design/fec_ram_sdp.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module fec_ram_sdp #(
    parameter int ADDR_WID = `FEC_ADDR_WID,
    parameter int DATA_WID = `FEC_RAM_WID
) (
    input  logic                clk,

    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,

    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int DEPTH = 1 << ADDR_WID;

    // storage, maps onto one block ram.
    logic [DATA_WID-1:0] mem [DEPTH];

    // write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port, one cycle latency.
    // a read of the address being written returns the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* fec_col_buf/fec_col_buf.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module fec_col_buf (
    input  logic                             clk,

    input  fec_pkg::buf_wr_t                 wr_req,
    input  logic [`FEC_BUF_IDX_WID-1:0]      wr_sel,

    input  fec_pkg::buf_rd_t                 rd_req,
    input  logic [`FEC_BUF_IDX_WID-1:0]      rd_sel,
    output fec_pkg::col_word_t               rd_data
);

    import fec_pkg::*;

    // --------------------
    // buffer array
    // --------------------

    // read data of every buffer, before the output select.
    col_word_t buf_dout [`FEC_NUM_BUFS];

    // select that lines up with the ram read latency.
    logic [`FEC_BUF_IDX_WID-1:0] rd_sel_q;

    // each buffer is 4 banks x 2 rams of 512 x 64.
    // row slice k = bank * 2 + ram lands in ram k.
    for (genvar b = 0; b < `FEC_NUM_BUFS; b++) begin : g_buf
        logic buf_wr_en;
        logic buf_rd_en;

        // enables per buffer, so one fills while the other drains.
        assign buf_wr_en = wr_req.en && (wr_sel == `FEC_BUF_IDX_WID'(b));
        assign buf_rd_en = rd_req.en && (rd_sel == `FEC_BUF_IDX_WID'(b));

        for (genvar bank = 0; bank < `FEC_NUM_BANKS; bank++) begin : g_bank
            for (genvar ram = 0; ram < `FEC_RAMS_PER_BANK; ram++) begin : g_ram
                localparam int K = bank * `FEC_RAMS_PER_BANK + ram;

                fec_ram_sdp #(
                    .ADDR_WID(`FEC_ADDR_WID),
                    .DATA_WID(`FEC_RAM_WID)
                ) u_ram (
                    .clk     (clk),
                    .wr_en   (buf_wr_en),
                    .wr_addr (wr_req.addr),
                    .wr_data (wr_req.data[K*`FEC_RAM_WID +: `FEC_RAM_WID]),
                    .rd_en   (buf_rd_en),
                    .rd_addr (rd_req.addr),
                    .rd_data (buf_dout[b][K*`FEC_RAM_WID +: `FEC_RAM_WID])
                );
            end
        end
    end

    // --------------------
    // output select
    // --------------------

    // follow the buffer whose read is in flight.
    always_ff @(posedge clk) begin
        if (rd_req.en) begin
            rd_sel_q <= rd_sel;
        end
    end

    assign rd_data = buf_dout[rd_sel_q];

endmodule

/* fec_col_buf/fec_buf_ctrl.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module fec_buf_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,

    // row input.
    input  logic                             in_valid,
    input  fec_pkg::col_word_t               in_data,
    output logic                             in_ready,
    output logic                             overflow,

    // write side of the buffer array.
    output fec_pkg::buf_wr_t                 wr_req,
    output logic [`FEC_BUF_IDX_WID-1:0]      wr_sel,

    // block handoff to the reader.
    output logic                             full_pulse,
    output logic [`FEC_BUF_IDX_WID-1:0]      full_idx,
    input  logic                             drain_done,
    input  logic [`FEC_BUF_IDX_WID-1:0]      drain_idx
);

    import fec_pkg::*;

    // --------------------
    // state
    // --------------------

    buf_state_e                  state_q [`FEC_NUM_BUFS];
    logic [`FEC_ADDR_WID-1:0]    wr_cnt;
    logic [`FEC_BUF_IDX_WID-1:0] wr_idx;

    logic accept;
    logic last_row;
    logic any_draining;

    // --------------------
    // input side
    // --------------------

    // open for rows while the write buffer still has room.
    always_comb begin
        in_ready = (state_q[wr_idx] == BUF_EMPTY) || (state_q[wr_idx] == BUF_FILLING);
    end

    assign accept   = in_valid && in_ready;
    assign overflow = in_valid && !in_ready;
    assign last_row = (wr_cnt == `FEC_ADDR_WID'(`FEC_DEPTH - 1));

    // write straight through from the input.
    assign wr_req.en   = accept;
    assign wr_req.addr = wr_cnt;
    assign wr_req.data = in_data;
    assign wr_sel      = wr_idx;

    // last row of a block hands the buffer over.
    assign full_pulse = accept && last_row;
    assign full_idx   = wr_idx;

    // only one buffer drains at a time.
    always_comb begin
        any_draining = 1'b0;
        for (int b = 0; b < `FEC_NUM_BUFS; b++) begin
            if (state_q[b] == BUF_DRAINING) begin
                any_draining = 1'b1;
            end
        end
    end

    // --------------------
    // buffer FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < `FEC_NUM_BUFS; b++) begin
                state_q[b] <= BUF_EMPTY;
            end
            wr_cnt <= '0;
            wr_idx <= '0;
        end else begin
            if (accept) begin
                wr_cnt <= last_row ? '0 : wr_cnt + 1'b1;
                // move on to the next buffer in turn.
                if (last_row) begin
                    if (wr_idx == `FEC_BUF_IDX_WID'(`FEC_NUM_BUFS - 1)) begin
                        wr_idx <= '0;
                    end else begin
                        wr_idx <= wr_idx + 1'b1;
                    end
                end
            end

            for (int b = 0; b < `FEC_NUM_BUFS; b++) begin
                if (drain_done && (drain_idx == `FEC_BUF_IDX_WID'(b))) begin
                    state_q[b] <= BUF_EMPTY;
                end else if (accept && (wr_idx == `FEC_BUF_IDX_WID'(b))) begin
                    state_q[b] <= last_row ? BUF_FULL : BUF_FILLING;
                end else if ((state_q[b] == BUF_FULL) && !any_draining) begin
                    // waiting block takes over once the reader is free.
                    state_q[b] <= BUF_DRAINING;
                end
            end
        end
    end

endmodule

/* design/fec_col_reader.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module fec_col_reader (
    input  logic                             clk,
    input  logic                             rst_n,

    // full blocks from the controller.
    input  logic                             full_pulse,
    input  logic [`FEC_BUF_IDX_WID-1:0]      full_idx,

    // read side of the buffer array.
    output fec_pkg::buf_rd_t                 rd_req,
    output logic [`FEC_BUF_IDX_WID-1:0]      rd_sel,
    input  fec_pkg::col_word_t               rd_data,

    // buffer release.
    output logic                             drain_done,
    output logic [`FEC_BUF_IDX_WID-1:0]      drain_idx,

    // interleaved output stream.
    output logic                             out_valid,
    output fec_pkg::col_word_t               out_data,
    output logic                             out_last
);

    import fec_pkg::*;

    // index i splits into column i / 64 and row i mod 64.
    localparam int COL_W = $clog2(`FEC_STRIDE);
    localparam int ROW_W = `FEC_ADDR_WID - COL_W;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'd0,
        RD_DRAIN = 2'd1,
        RD_DONE  = 2'd2
    } rd_state_e;

    rd_state_e                   state_q;
    logic [ROW_W-1:0]            row_cnt;
    logic [COL_W-1:0]            col_cnt;
    logic [`FEC_BUF_IDX_WID-1:0] cur_idx;
    logic                        pend_vld;
    logic [`FEC_BUF_IDX_WID-1:0] pend_idx;
    buf_rd_t                     rd_q;

    logic                        start_go;
    logic [`FEC_BUF_IDX_WID-1:0] start_idx;
    logic                        last_issue;
    logic                        v1;
    logic                        l1;

    // older full block goes first.
    assign start_go   = (state_q == RD_IDLE) && (pend_vld || full_pulse);
    assign start_idx  = pend_vld ? pend_idx : full_idx;
    assign last_issue = (state_q == RD_DRAIN) && (&row_cnt) && (&col_cnt);

    assign rd_req     = rd_q;
    assign rd_sel     = cur_idx;
    assign drain_done = (state_q == RD_DONE);
    assign drain_idx  = cur_idx;

    // --------------------
    // address engine
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= RD_IDLE;
            row_cnt  <= '0;
            col_cnt  <= '0;
            cur_idx  <= '0;
            pend_vld <= 1'b0;
            pend_idx <= '0;
            rd_q     <= '0;
        end else begin
            rd_q.en <= 1'b0;

            // hold a block that is full while another drains.
            if (full_pulse && !(start_go && !pend_vld)) begin
                pend_vld <= 1'b1;
                pend_idx <= full_idx;
            end else if (start_go) begin
                pend_vld <= 1'b0;
            end

            case (state_q)
                RD_IDLE: begin
                    if (start_go) begin
                        state_q <= RD_DRAIN;
                        cur_idx <= start_idx;
                        // index 0 goes out with the start.
                        rd_q    <= '{en: 1'b1, addr: '0};
                        row_cnt <= ROW_W'(1);
                        col_cnt <= '0;
                    end
                end
                RD_DRAIN: begin
                    // address is row * stride + column.
                    rd_q.en   <= 1'b1;
                    rd_q.addr <= {row_cnt, col_cnt};
                    row_cnt   <= row_cnt + 1'b1;
                    if (&row_cnt) begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                    if (last_issue) begin
                        state_q <= RD_DONE;
                    end
                end
                RD_DONE: begin
                    state_q <= RD_IDLE;
                end
                default: begin
                    state_q <= RD_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // output stage
    // --------------------

    // valid and last follow the ram read by two stages.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            l1        <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            v1        <= rd_q.en;
            l1        <= drain_done;
            out_valid <= v1;
            out_last  <= l1;
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            out_data <= rd_data;
        end
    end

endmodule

/* design/fec_interleaver_top.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module fec_interleaver_top (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               in_valid,
    input  fec_pkg::col_word_t in_data,
    output logic               in_ready,
    output logic               overflow,

    output logic               out_valid,
    output fec_pkg::col_word_t out_data,
    output logic               out_last
);

    import fec_pkg::*;

    // --------------------
    // internal wires
    // --------------------

    buf_wr_t                     wr_req;
    logic [`FEC_BUF_IDX_WID-1:0] wr_sel;
    buf_rd_t                     rd_req;
    logic [`FEC_BUF_IDX_WID-1:0] rd_sel;
    col_word_t                   rd_data;

    logic                        full_pulse;
    logic [`FEC_BUF_IDX_WID-1:0] full_idx;
    logic                        drain_done;
    logic [`FEC_BUF_IDX_WID-1:0] drain_idx;

    // fill side.
    fec_buf_ctrl u_buf_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .overflow   (overflow),
        .wr_req     (wr_req),
        .wr_sel     (wr_sel),
        .full_pulse (full_pulse),
        .full_idx   (full_idx),
        .drain_done (drain_done),
        .drain_idx  (drain_idx)
    );

    // ping-pong storage.
    fec_col_buf u_col_buf (
        .clk     (clk),
        .wr_req  (wr_req),
        .wr_sel  (wr_sel),
        .rd_req  (rd_req),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

    // drain side.
    fec_col_reader u_col_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .full_pulse (full_pulse),
        .full_idx   (full_idx),
        .rd_req     (rd_req),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .drain_done (drain_done),
        .drain_idx  (drain_idx),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last)
    );

endmodule

/* bench/tb_fec_interleaver.sv */
`timescale 1ns/100ps
`include "fec_defines.svh"

module tb_fec_interleaver;

    import fec_pkg::*;

    localparam int CLK_HALF         = 5;
    localparam int CLK_PERIOD       = 2 * CLK_HALF;
    localparam int DEPTH            = `FEC_DEPTH;
    localparam int COLS             = `FEC_DEPTH / `FEC_STRIDE;
    localparam int LATENCY          = 3;
    localparam int WATCHDOG_BLOCKS  = 6;
    localparam int CYCLES_PER_BLOCK = 520;
    localparam int MARGIN_CYCLES    = 2000;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    col_word_t in_data;
    logic      in_ready;
    logic      overflow;
    logic      out_valid;
    col_word_t out_data;
    logic      out_last;

    integer    seed;
    string     test_name;

    // reference model state.
    col_word_t rows [$];
    col_word_t dropped [$];
    int        first_due [$];
    string     block_name [$];
    int        cycle;
    int        blocks_full;
    int        blocks_out;
    int        out_idx;
    int        run_len;
    int        overflow_cnt;

    fec_interleaver_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .overflow  (overflow),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #CLK_HALF clk = ~clk;

    // --------------------
    // error reporting
    // --------------------

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input col_word_t expected, input col_word_t actual);
        $display("CHECK FAILED test=%s check=%s expected=%0h actual=%0h",
                 name, what, expected, actual);
        stop_run();
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s (test %s)", msg, test_name);
        stop_run();
    endtask

    // --------------------
    // protocol assertions
    // --------------------

    assert property (@(posedge clk) disable iff (!rst_n) out_last |-> out_valid)
        else report_mismatch(test_name, "last_without_valid",
                             col_word_t'(1'b1), col_word_t'($sampled(out_valid)));

    // --------------------
    // monitor and model
    // --------------------

    always @(posedge clk) begin : monitor
        int   pos;
        logic exp_ready;
        if (rst_n) begin
            cycle = cycle + 1;

            // two held blocks fill both buffers until the older one
            // issues its last read, two rows before its last output.
            exp_ready = (blocks_full - blocks_out < 2) || (out_idx >= DEPTH - 2);
            assert (in_ready == exp_ready)
                else report_mismatch(test_name, "in_ready",
                                     col_word_t'(exp_ready), col_word_t'(in_ready));
            // a row offered while not ready is dropped with a pulse.
            assert (overflow == (in_valid && !exp_ready))
                else report_mismatch(test_name, "overflow_rule",
                                     col_word_t'(in_valid && !exp_ready),
                                     col_word_t'(overflow));

            if (out_valid) begin
                run_len = run_len + 1;
                assert (run_len <= DEPTH)
                    else report_problem("out_valid stayed high for more than one block");
                assert (blocks_out < blocks_full)
                    else report_problem("an output row appeared before its block was full");
                if (out_idx == 0 && first_due[blocks_out] >= 0) begin
                    assert (cycle == first_due[blocks_out])
                        else report_mismatch(block_name[blocks_out], "first_row_latency",
                                             col_word_t'(first_due[blocks_out]),
                                             col_word_t'(cycle));
                end
                // column order, stride 8 through the stored rows.
                pos = blocks_out * DEPTH + (out_idx % COLS) * `FEC_STRIDE + out_idx / COLS;
                assert (out_data === rows[pos])
                    else report_mismatch(block_name[blocks_out], "row_data",
                                         rows[pos], out_data);
                assert (out_last == (out_idx == DEPTH - 1))
                    else report_mismatch(block_name[blocks_out], "last_position",
                                         col_word_t'(out_idx == DEPTH - 1),
                                         col_word_t'(out_last));
                foreach (dropped[j]) begin
                    assert (out_data !== dropped[j])
                        else report_problem("a dropped row appeared at the output");
                end
                if (out_idx == DEPTH - 1) begin
                    out_idx    = 0;
                    blocks_out = blocks_out + 1;
                end else begin
                    out_idx = out_idx + 1;
                end
            end else begin
                run_len = 0;
                assert (out_idx == 0)
                    else report_problem("out_valid dropped in the middle of a block");
            end

            if (overflow) begin
                overflow_cnt = overflow_cnt + 1;
            end
            if (in_valid && !exp_ready) begin
                dropped.push_back(in_data);
            end

            if (in_valid && exp_ready) begin
                if (rows.size() % DEPTH == 0) begin
                    block_name.push_back(test_name);
                end
                rows.push_back(in_data);
                if (rows.size() % DEPTH == 0) begin
                    // latency is only fixed with the reader idle.
                    if (blocks_full == blocks_out) begin
                        first_due.push_back(cycle + LATENCY);
                    end else begin
                        first_due.push_back(-1);
                    end
                    blocks_full = blocks_full + 1;
                end
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------

    function automatic col_word_t random_row();
        col_word_t row;
        for (int k = 0; k < `FEC_WORD_WID / 32; k++) begin
            row[k*32 +: 32] = $random(seed);
        end
        return row;
    endfunction

    // called on a falling edge, returns on one.
    task automatic send_rows(input int count, input bit gaps);
        int target;
        target = rows.size() + count;
        while (rows.size() < target) begin
            in_valid = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            in_data  = random_row();
            @(negedge clk);
        end
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (blocks_out != blocks_full && n < max_cycles) begin
            @(negedge clk);
            n = n + 1;
        end
        if (blocks_out != blocks_full) begin
            report_problem("the output did not drain every full block in time");
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        seed         = 32'he284;
        test_name    = "reset";
        cycle        = 0;
        blocks_full  = 0;
        blocks_out   = 0;
        out_idx      = 0;
        run_len      = 0;
        overflow_cnt = 0;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_name = "idle_after_reset";
        assert ({in_ready, out_valid, out_last, overflow} == 4'b1000)
            else report_mismatch(test_name, "idle_outputs", col_word_t'(4'b1000),
                                 col_word_t'({in_ready, out_valid, out_last, overflow}));

        test_name = "single_block_gaps";
        send_rows(DEPTH, 1'b1);
        in_valid = 1'b0;
        wait_drained(2 * DEPTH + 20);

        // buffers overlap fill and drain.
        test_name = "three_blocks_streamed";
        send_rows(3 * DEPTH, 1'b0);

        // no break, so the write side catches up with the drain.
        test_name = "overflow_when_full";
        send_rows(DEPTH, 1'b0);
        in_valid = 1'b0;
        wait_drained(2 * DEPTH + 20);

        if (overflow_cnt == 0 || blocks_out != 5) begin
            report_problem("no overflow was seen or a block is missing at the output");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // --------------------
    // watchdog
    // --------------------

    initial begin
        #((WATCHDOG_BLOCKS * CYCLES_PER_BLOCK + MARGIN_CYCLES) * CLK_PERIOD);
        report_problem("watchdog timeout, the run did not finish in time");
    end

endmodule

/* sources.f */
+incdir+common
common/fec_pkg.sv
design/fec_ram_sdp.sv
fec_col_buf/fec_col_buf.sv
fec_col_buf/fec_buf_ctrl.sv
design/fec_col_reader.sv
design/fec_interleaver_top.sv
bench/tb_fec_interleaver.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fec_interleaver
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_TEXT := RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
